// ==== fracModTop.f ====
+incdir+include
logic/fracModPkg.sv
logic/fracModCtrl.sv
logic/stepCounter.sv
logic/seqDivider.sv
logic/euclidRegs.sv
logic/fracModTop.sv
tests/fracModTb.sv

// ==== include/fracMod_cfg.svh ====
`ifndef FRAC_MOD_CFG_SVH
`define FRAC_MOD_CFG_SVH

// Modulus and reduced values
`define FRAC_MOD_W 12

// Numerator and denominator
`define FRAC_OP_W 13

// Products, dividends and quotients
`define FRAC_PROD_W 25

`define FRAC_DIV_STEPS `FRAC_PROD_W

`endif

// ==== logic/euclidRegs.sv ====
`timescale 1ns/1ns
`include "fracMod_cfg.svh"

module euclidRegs (
    input  logic              clk,
    input  logic              rstN,
    input  logic              init,
    input  fracModPkg::divOpT divSel,
    input  logic              latchQuot,
    input  logic              latchProd,
    input  logic              advance,
    input  logic              latchResult,
    input  logic              setOne,
    input  fracModPkg::opT    num,
    input  fracModPkg::opT    den,
    input  fracModPkg::modT   modu,
    input  fracModPkg::prodT  quotient,
    input  fracModPkg::prodT  remainder,
    output fracModPkg::prodT  dividend,
    output fracModPkg::prodT  divisor,
    output logic              badOperands,
    output logic              sameOperands,
    output logic              remZero,
    output logic              gcdOne,
    output fracModPkg::modT   result
);

    fracModPkg::opT       numReg;
    fracModPkg::opT       denReg;
    fracModPkg::modT      modReg;
    fracModPkg::opT       r0;
    fracModPkg::opT       r1;
    fracModPkg::opT       remHold;
    fracModPkg::opT       qReg;
    fracModPkg::modT      t0;
    fracModPkg::modT      t1;
    fracModPkg::modT      prodRed;
    fracModPkg::prodT     qProd;
    fracModPkg::prodT     resProd;
    logic [`FRAC_MOD_W:0] tWrap;
    fracModPkg::modT      tSub;

    //////////////////////////////
    // Operand checks
    //////////////////////////////

    assign badOperands  = (numReg == fracModPkg::opT'(modReg)) ||
                          (denReg == fracModPkg::opT'(modReg)) ||
                          (denReg == '0) ||
                          (modReg < fracModPkg::modT'(2));
    assign sameOperands = (numReg == denReg);
    assign remZero      = (r1 == '0);
    assign gcdOne       = (r0 == fracModPkg::opT'(1));

    //////////////////////////////
    // Products and divider inputs
    //////////////////////////////

    assign qProd   = fracModPkg::prodT'(qReg) * fracModPkg::prodT'(t1);
    assign resProd = fracModPkg::prodT'(numReg) * fracModPkg::prodT'(t0);

    always_comb begin
        case (divSel)
            fracModPkg::product: begin
                dividend = qProd;
                divisor  = fracModPkg::prodT'(modReg);
            end
            fracModPkg::result: begin
                dividend = resProd;
                divisor  = fracModPkg::prodT'(modReg);
            end
            default: begin
                dividend = fracModPkg::prodT'(r0);
                divisor  = fracModPkg::prodT'(r1);
            end
        endcase
    end

    // t0 - q*t1 kept in [0, m)
    assign tWrap = {1'b0, t0} + {1'b0, modReg} - {1'b0, prodRed};
    assign tSub  = (t0 >= prodRed) ? (t0 - prodRed) : tWrap[`FRAC_MOD_W-1:0];

    //////////////////////////////
    // Euclid register set
    //////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            numReg  <= '0;
            denReg  <= '0;
            modReg  <= '0;
            r0      <= '0;
            r1      <= '0;
            t0      <= '0;
            t1      <= '0;
            qReg    <= '0;
            remHold <= '0;
            prodRed <= '0;
        end else if (init) begin
            numReg <= num;
            denReg <= den;
            modReg <= modu;
            r0     <= fracModPkg::opT'(modu);
            r1     <= den;
            t0     <= '0;
            t1     <= fracModPkg::modT'(1);
        end else begin
            if (latchQuot) begin
                qReg    <= quotient[`FRAC_OP_W-1:0];
                remHold <= remainder[`FRAC_OP_W-1:0];
            end
            if (latchProd) begin
                prodRed <= remainder[`FRAC_MOD_W-1:0];
            end
            if (advance) begin
                r0 <= r1;
                r1 <= remHold;
                t0 <= t1;
                t1 <= tSub;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            result <= '0;
        end else if (init) begin
            result <= '0;
        end else if (latchResult) begin
            result <= remainder[`FRAC_MOD_W-1:0];
        end else if (setOne) begin
            result <= fracModPkg::modT'(1);
        end
    end

endmodule

// ==== logic/fracModCtrl.sv ====
`timescale 1ns/1ns

module fracModCtrl (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   start,
    input  logic                   badOperands,
    input  logic                   sameOperands,
    input  logic                   remZero,
    input  logic                   gcdOne,
    input  logic                   divDone,
    output logic                   init,
    output fracModPkg::divOpT      divSel,
    output logic                   divStart,
    output logic                   latchQuot,
    output logic                   latchProd,
    output logic                   advance,
    output logic                   latchResult,
    output logic                   setOne,
    output logic                   busy,
    output logic                   done,
    output fracModPkg::fracStatusT status
);

    fracModPkg::ctrlStateT state;
    fracModPkg::ctrlStateT nextState;
    logic                  divRunning;

    //////////////////////////////
    // State and status registers
    //////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= fracModPkg::idle;
        end else begin
            state <= nextState;
        end
    end

    // Set by divStart, cleared when the divider reports back
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            divRunning <= 1'b0;
        end else if (divStart) begin
            divRunning <= 1'b1;
        end else if (divDone) begin
            divRunning <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            status <= fracModPkg::ok;
        end else if (init) begin
            status <= fracModPkg::ok;
        end else if (state == fracModPkg::check && badOperands) begin
            status <= fracModPkg::invalid;
        end else if (state == fracModPkg::check && sameOperands) begin
            status <= fracModPkg::identity;
        end else if (state == fracModPkg::testRem && remZero && !gcdOne) begin
            status <= fracModPkg::noInverse;
        end
    end

    //////////////////////////////
    // Next state and strobes
    //////////////////////////////

    always_comb begin
        nextState   = state;
        init        = 1'b0;
        divSel      = fracModPkg::quotient;
        divStart    = 1'b0;
        latchQuot   = 1'b0;
        latchProd   = 1'b0;
        advance     = 1'b0;
        latchResult = 1'b0;
        setOne      = 1'b0;
        done        = 1'b0;
        case (state)
            fracModPkg::idle: begin
                if (start) begin
                    init      = 1'b1;
                    nextState = fracModPkg::check;
                end
            end
            fracModPkg::check: begin
                if (badOperands) begin
                    nextState = fracModPkg::finish;
                end else if (sameOperands) begin
                    setOne    = 1'b1;
                    nextState = fracModPkg::finish;
                end else begin
                    nextState = fracModPkg::divide;
                end
            end
            // r0 / r1
            fracModPkg::divide: begin
                divStart = !divRunning;
                if (divDone) begin
                    latchQuot = 1'b1;
                    nextState = fracModPkg::reduceProd;
                end
            end
            // q * t1 mod m
            fracModPkg::reduceProd: begin
                divSel   = fracModPkg::product;
                divStart = !divRunning;
                if (divDone) begin
                    latchProd = 1'b1;
                    nextState = fracModPkg::advance;
                end
            end
            fracModPkg::advance: begin
                advance   = 1'b1;
                nextState = fracModPkg::testRem;
            end
            fracModPkg::testRem: begin
                if (!remZero) begin
                    nextState = fracModPkg::divide;
                end else if (gcdOne) begin
                    nextState = fracModPkg::finalMul;
                end else begin
                    nextState = fracModPkg::finish;
                end
            end
            // num * t0 mod m
            fracModPkg::finalMul: begin
                divSel   = fracModPkg::result;
                divStart = !divRunning;
                if (divDone) begin
                    latchResult = 1'b1;
                    nextState   = fracModPkg::finish;
                end
            end
            fracModPkg::finish: begin
                done      = 1'b1;
                nextState = fracModPkg::idle;
            end
            default: begin
                nextState = fracModPkg::idle;
            end
        endcase
    end

    assign busy = (state != fracModPkg::idle);

    // Divider only reports back on an outstanding division
    assert property (@(posedge clk) disable iff (!rstN) divDone |-> divRunning);

endmodule

// ==== logic/fracModPkg.sv ====
package fracModPkg;

`include "fracMod_cfg.svh"

    typedef logic [`FRAC_MOD_W-1:0] modT;
    typedef logic [`FRAC_OP_W-1:0] opT;
    typedef logic [`FRAC_PROD_W-1:0] prodT;
    typedef logic [$clog2(`FRAC_DIV_STEPS + 1) - 1:0] stepT;

    typedef enum logic [2:0] {
        idle, check, divide, reduceProd, advance, testRem, finalMul, finish
    } ctrlStateT;

    // Divider operand pairs
    typedef enum logic [1:0] {quotient, product, result} divOpT;

    typedef enum logic [1:0] {ok, invalid, identity, noInverse} fracStatusT;

endpackage

// ==== logic/fracModTop.sv ====
`timescale 1ns/1ns

module fracModTop (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   start,
    input  fracModPkg::opT         num,
    input  fracModPkg::opT         den,
    input  fracModPkg::modT        modu,
    output logic                   busy,
    output logic                   done,
    output fracModPkg::modT        result,
    output fracModPkg::fracStatusT status
);

    logic              init;
    fracModPkg::divOpT divSel;
    logic              divStart;
    logic              latchQuot;
    logic              latchProd;
    logic              advance;
    logic              latchResult;
    logic              setOne;
    logic              badOperands;
    logic              sameOperands;
    logic              remZero;
    logic              gcdOne;
    logic              stepEn;
    logic              lastStep;
    logic              divDone;
    fracModPkg::prodT  dividend;
    fracModPkg::prodT  divisor;
    fracModPkg::prodT  quotient;
    fracModPkg::prodT  remainder;

    fracModCtrl fracModCtrl_inst (
        .clk          (clk),
        .rstN         (rstN),
        .start        (start),
        .badOperands  (badOperands),
        .sameOperands (sameOperands),
        .remZero      (remZero),
        .gcdOne       (gcdOne),
        .divDone      (divDone),
        .init         (init),
        .divSel       (divSel),
        .divStart     (divStart),
        .latchQuot    (latchQuot),
        .latchProd    (latchProd),
        .advance      (advance),
        .latchResult  (latchResult),
        .setOne       (setOne),
        .busy         (busy),
        .done         (done),
        .status       (status)
    );

    stepCounter stepCounter_inst (
        .clk      (clk),
        .rstN     (rstN),
        .load     (divStart),
        .stepEn   (stepEn),
        .lastStep (lastStep)
    );

    // Shared by the Euclid quotient and every reduction mod m
    seqDivider seqDivider_inst (
        .clk       (clk),
        .rstN      (rstN),
        .load      (divStart),
        .stepEn    (stepEn),
        .lastStep  (lastStep),
        .dividend  (dividend),
        .divisor   (divisor),
        .quotient  (quotient),
        .remainder (remainder),
        .divDone   (divDone)
    );

    euclidRegs euclidRegs_inst (
        .clk          (clk),
        .rstN         (rstN),
        .init         (init),
        .divSel       (divSel),
        .latchQuot    (latchQuot),
        .latchProd    (latchProd),
        .advance      (advance),
        .latchResult  (latchResult),
        .setOne       (setOne),
        .num          (num),
        .den          (den),
        .modu         (modu),
        .quotient     (quotient),
        .remainder    (remainder),
        .dividend     (dividend),
        .divisor      (divisor),
        .badOperands  (badOperands),
        .sameOperands (sameOperands),
        .remZero      (remZero),
        .gcdOne       (gcdOne),
        .result       (result)
    );

endmodule

// ==== logic/seqDivider.sv ====
`timescale 1ns/1ns
`include "fracMod_cfg.svh"

module seqDivider (
    input  logic             clk,
    input  logic             rstN,
    input  logic             load,
    input  logic             stepEn,
    input  logic             lastStep,
    input  fracModPkg::prodT dividend,
    input  fracModPkg::prodT divisor,
    output fracModPkg::prodT quotient,
    output fracModPkg::prodT remainder,
    output logic             divDone
);

    fracModPkg::prodT        divReg;
    fracModPkg::prodT        quoReg;
    fracModPkg::prodT        remReg;
    logic [`FRAC_PROD_W:0]   trial;
    logic [`FRAC_PROD_W:0]   diff;
    logic                    fits;

    // Partial remainder with the next dividend bit shifted in
    assign trial = {remReg, quoReg[`FRAC_PROD_W-1]};
    assign diff  = trial - {1'b0, divReg};
    assign fits  = (trial >= {1'b0, divReg});

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            divReg <= '0;
            quoReg <= '0;
            remReg <= '0;
        end else if (load) begin
            divReg <= divisor;
            quoReg <= dividend;
            remReg <= '0;
        end else if (stepEn) begin
            // Dividend bits leave at the top, quotient bits enter at the bottom
            quoReg <= {quoReg[`FRAC_PROD_W-2:0], fits};
            if (fits) begin
                remReg <= diff[`FRAC_PROD_W-1:0];
            end else begin
                remReg <= trial[`FRAC_PROD_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            divDone <= 1'b0;
        end else begin
            divDone <= lastStep;
        end
    end

    assign quotient  = quoReg;
    assign remainder = remReg;

    assert property (@(posedge clk) disable iff (!rstN) load |-> divisor != '0);

endmodule

// ==== logic/stepCounter.sv ====
`timescale 1ns/1ns
`include "fracMod_cfg.svh"

module stepCounter (
    input  logic clk,
    input  logic rstN,
    input  logic load,
    output logic stepEn,
    output logic lastStep
);

    fracModPkg::stepT count;

    // Counts down from the step total to zero
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (load) begin
            count <= fracModPkg::stepT'(`FRAC_DIV_STEPS);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign stepEn   = (count != '0);
    assign lastStep = (count == fracModPkg::stepT'(1));

    // A new division must wait for the running one
    assert property (@(posedge clk) disable iff (!rstN) load |-> !stepEn);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the fraction-modulo engine testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f fracModTop.f --top-module fracModTb -o fracModSim &&
    ./obj_dir/fracModSim | tee /dev/stderr | grep -qx "TEST PASS" &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

// ==== tests/fracModTb.sv ====
`timescale 1ns/1ns

module fracModTb;

    localparam int clkPeriod   = 10;
    localparam int numOps      = 220;
    // Roughly 18 Euclid rounds of two divisions each, plus the final one
    localparam int worstCycles = 1500;
    localparam int timeoutNs   = numOps * worstCycles * clkPeriod + 100 * clkPeriod;

    logic                   clk;
    logic                   rstN;
    logic                   start;
    fracModPkg::opT         num;
    fracModPkg::opT         den;
    fracModPkg::modT        modu;
    logic                   busy;
    logic                   done;
    fracModPkg::modT        result;
    fracModPkg::fracStatusT status;

    // One entry per accepted start
    fracModPkg::fracStatusT expStatusQ[$];
    fracModPkg::modT        expResultQ[$];
    string                  descQ[$];

    fracModPkg::fracStatusT expSt;
    fracModPkg::modT        expRes;
    string                  expDesc;
    int                     errorCount;
    int                     acceptCount;
    int                     doneCount;
    int                     groupCount;
    int                     groupOps;
    int                     groupErrors;
    logic                   doneLast;
    int                     rn;
    int                     rd;
    int                     rm;

    fracModTop fracModTop_inst (
        .clk    (clk),
        .rstN   (rstN),
        .start  (start),
        .num    (num),
        .den    (den),
        .modu   (modu),
        .busy   (busy),
        .done   (done),
        .result (result),
        .status (status)
    );

    always #(clkPeriod / 2) clk = ~clk;

    ////////////////////////////////
    // Reference model
    ////////////////////////////////

    function automatic void expectedOutcome(input int n, input int d, input int m,
            output fracModPkg::fracStatusT st, output fracModPkg::modT res);
        int oldR;
        int r;
        int oldT;
        int t;
        int q;
        int tmp;
        st  = fracModPkg::ok;
        res = '0;
        if (n == m || d == m || d == 0 || m < 2) begin
            st = fracModPkg::invalid;
        end else if (n == d) begin
            st  = fracModPkg::identity;
            res = fracModPkg::modT'(1);
        end else begin
            oldR = m;
            r    = d;
            oldT = 0;
            t    = 1;
            while (r != 0) begin
                q    = oldR / r;
                tmp  = oldR - q * r;
                oldR = r;
                r    = tmp;
                tmp  = oldT - q * t;
                oldT = t;
                t    = tmp;
            end
            if (oldR != 1) begin
                st = fracModPkg::noInverse;
            end else begin
                tmp = oldT % m;
                if (tmp < 0) begin
                    tmp = tmp + m;
                end
                res = fracModPkg::modT'((n * tmp) % m);
            end
        end
    endfunction

    ////////////////////////////////
    // Comparison
    ////////////////////////////////

    always @(posedge clk) begin
        if (rstN) begin
            if (doneLast && (busy || done)) begin
                $display("CHECK FAILED busy/done: got 0x%0h/0x%0h expected 0x0/0x0 after done",
                         busy, done);
                errorCount++;
            end
            if (done) begin
                doneCount++;
                if (expStatusQ.size() == 0) begin
                    $display("Done pulsed with no accepted start outstanding");
                    errorCount++;
                end else begin
                    expSt   = expStatusQ.pop_front();
                    expRes  = expResultQ.pop_front();
                    expDesc = descQ.pop_front();
                    if (status !== expSt) begin
                        $display("CHECK FAILED status: got 0x%0h expected 0x%0h (%s)",
                                 status, expSt, expDesc);
                        errorCount++;
                    end
                    if (result !== expRes) begin
                        $display("CHECK FAILED result: got 0x%0h expected 0x%0h (%s)",
                                 result, expRes, expDesc);
                        errorCount++;
                    end
                end
            end
            doneLast = done;
        end
    end

    ////////////////////////////////
    // Stimulus
    ////////////////////////////////

    task automatic runOp(input int n, input int d, input int m, input bit pokeWhileBusy);
        fracModPkg::fracStatusT st;
        fracModPkg::modT        res;
        expectedOutcome(n, d, m, st, res);
        @(posedge clk);
        while (busy) begin
            @(posedge clk);
        end
        expStatusQ.push_back(st);
        expResultQ.push_back(res);
        descQ.push_back($sformatf("num 0x%0h den 0x%0h modu 0x%0h", n, d, m));
        start <= 1'b1;
        num   <= fracModPkg::opT'(n);
        den   <= fracModPkg::opT'(d);
        modu  <= fracModPkg::modT'(m);
        @(posedge clk);
        start <= 1'b0;
        acceptCount++;
        groupOps++;
        @(posedge clk);
        if (!busy) begin
            $display("CHECK FAILED busy: got 0x%0h expected 0x1 after an accepted start",
                     busy);
            errorCount++;
        end
        if (pokeWhileBusy) begin
            // Different operands, must be ignored
            repeat (3) @(posedge clk);
            start <= 1'b1;
            num   <= fracModPkg::opT'(13'h1a5);
            den   <= fracModPkg::opT'(13'h3);
            modu  <= fracModPkg::modT'(12'h7);
            @(posedge clk);
            start <= 1'b0;
        end
        while (!done) begin
            @(posedge clk);
        end
        @(posedge clk);
    endtask

    task automatic pickOperands(output int n, output int d, output int m);
        m = 2 + int'($urandom % 4094);
        if ($urandom % 2) begin
            d = 1 + int'($urandom % (m - 1));
        end else begin
            d = 1 + int'($urandom % 8191);
            while (d == m) begin
                d = 1 + int'($urandom % 8191);
            end
        end
        n = int'($urandom % 8192);
        while (n == m) begin
            n = int'($urandom % 8192);
        end
    endtask

    task automatic startGroup();
        groupOps    = 0;
        groupErrors = errorCount;
    endtask

    task automatic reportGroup(input string name);
        groupCount++;
        $display("%-16s %4d ops  %0d errors", name, groupOps, errorCount - groupErrors);
    endtask

    initial begin
        void'($urandom(32'h89d6));
        clk         = 1'b0;
        rstN        = 1'b0;
        start       = 1'b0;
        num         = '0;
        den         = '0;
        modu        = '0;
        errorCount  = 0;
        acceptCount = 0;
        doneCount   = 0;
        groupCount  = 0;
        doneLast    = 1'b0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);

        startGroup();
        if (busy !== 1'b0) begin
            $display("CHECK FAILED busy: got 0x%0h expected 0x0 after reset", busy);
            errorCount++;
        end
        if (done !== 1'b0) begin
            $display("CHECK FAILED done: got 0x%0h expected 0x0 after reset", done);
            errorCount++;
        end
        if (status !== fracModPkg::ok || result !== '0) begin
            $display("CHECK FAILED status/result: got 0x%0h/0x%0h after reset",
                     status, result);
            errorCount++;
        end
        runOp(5, 0, 11, 0);
        runOp(5, 11, 11, 0);
        runOp(11, 3, 11, 0);
        runOp(3, 4, 1, 0);
        runOp(3, 4, 0, 0);
        reportGroup("invalid");

        startGroup();
        runOp(9, 9, 13, 0);
        runOp(4000, 4000, 97, 0);
        reportGroup("identity");

        startGroup();
        runOp(3, 5, 7, 0);
        runOp(1, 2, 4093, 0);
        runOp(1000, 999, 4091, 0);
        runOp(8191, 8190, 4093, 0);
        runOp(17, 4001, 4095, 0);
        runOp(1, 3, 2, 0);
        reportGroup("coprime");

        startGroup();
        runOp(5, 6, 12, 0);
        runOp(7, 4000, 4095, 0);
        runOp(3, 8190, 4095, 0);
        runOp(1, 14, 21, 0);
        reportGroup("no inverse");

        startGroup();
        for (int i = 0; i < 200; i++) begin
            pickOperands(rn, rd, rm);
            runOp(rn, rd, rm, 0);
        end
        reportGroup("random");

        startGroup();
        runOp(1234, 567, 4093, 1);
        runOp(77, 2048, 4095, 1);
        reportGroup("start when busy");

        if (doneCount != acceptCount) begin
            $display("Saw %0d done pulses for %0d accepted starts", doneCount, acceptCount);
            errorCount++;
        end
        $display("%0d tests, %0d operations, %0d errors", groupCount, acceptCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule
